// File: sdmac_pkg.sv
// SDMAC shared definitions
`default_nettype none

package sdmac_pkg;

    // Bus widths
    localparam int unsigned BYTE_W     = 8;
    localparam int unsigned LONG_W     = 32;
    localparam int unsigned REG_ADDR_W = 5;

    // Longword FIFO geometry
    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CW    = FIFO_AW + 1;

    // Idle cycles after a DMA byte so the synchronized DREQ catches up
    localparam int unsigned DMA_GAP    = 3;
    localparam int unsigned GAP_W      = 2;

    // SCSI strobe engine states
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_REG_SETUP  = 3'd1,
        ST_REG_STROBE = 3'd2,
        ST_REG_DONE   = 3'd3,
        ST_DMA_STROBE = 3'd4,
        ST_DMA_HOLD   = 3'd5
    } scsi_state_e;

    // Transfer direction
    typedef enum logic {
        DIR_FROM_SCSI = 1'b0,
        DIR_TO_SCSI   = 1'b1
    } dma_dir_e;

    // Host register request, rw high for a read
    typedef struct packed {
        logic                  rw;
        logic [REG_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]     wdata;
    } reg_req_t;

    // Pins toward the SCSI chip, all active high
    typedef struct packed {
        logic                  cs;
        logic                  re;
        logic                  we;
        logic                  dack;
        logic [REG_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]     wdata;
        logic                  oe;
    } scsi_pins_t;

    // Byte engine commands to the FIFO
    typedef struct packed {
        logic s2f;
        logic f2s;
        logic inc_bo;
    } fifo_ctl_t;

endpackage

`default_nettype wire

// File: cpu_port.sv
// Host register access port
`timescale 1ns/100ps
`default_nettype none

module cpu_port (
    input  logic                         BCLK,
    input  logic                         CRESET_,
    input  logic                         reg_req_valid_i,
    input  sdmac_pkg::reg_req_t          reg_req_i,
    input  logic                         cpu_done_i,
    input  logic [sdmac_pkg::BYTE_W-1:0] cpu_rdata_i,
    output logic                         reg_req_ready_o,
    output logic                         reg_ack_o,
    output logic [sdmac_pkg::BYTE_W-1:0] reg_rdata_o,
    output logic                         cpu_req_valid_o,
    output sdmac_pkg::reg_req_t          cpu_req_o
);

    import sdmac_pkg::*;

    reg_req_t          req_q;
    logic [BYTE_W-1:0] rdata_q;
    logic              open_q;
    logic              ack_pend_q;
    logic              accept;

    // One request open at a time
    assign reg_req_ready_o = !open_q;
    assign accept          = reg_req_valid_i && reg_req_ready_o;
    assign cpu_req_o       = req_q;
    assign reg_rdata_o     = rdata_q;

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            open_q          <= 1'b0;
            cpu_req_valid_o <= 1'b0;
            ack_pend_q      <= 1'b0;
            reg_ack_o       <= 1'b0;
        end else begin
            ack_pend_q <= cpu_done_i && cpu_req_valid_o;
            reg_ack_o  <= ack_pend_q;
            if (accept) begin
                open_q          <= 1'b1;
                cpu_req_valid_o <= 1'b1;
            end else if (cpu_done_i) begin
                cpu_req_valid_o <= 1'b0;
            end
            // Port frees up together with the acknowledge
            if (ack_pend_q) begin
                open_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (accept) begin
            req_q <= reg_req_i;
        end
        if (cpu_done_i) begin
            rdata_q <= cpu_rdata_i;
        end
    end

    // Engine only finishes a request the port is holding
    assert property (@(posedge BCLK) disable iff (!CRESET_)
        cpu_done_i |-> cpu_req_valid_o);

endmodule

`default_nettype wire

// File: scsi_sm.sv
// SCSI strobe state machine
`timescale 1ns/100ps
`default_nettype none

module scsi_sm (
    input  logic                         BCLK,
    input  logic                         CRESET_,
    input  sdmac_pkg::dma_dir_e          dma_dir_i,
    input  logic                         dma_en_i,
    input  logic                         dreq_n_i,
    input  logic [sdmac_pkg::BYTE_W-1:0] scsi_data_i,
    input  logic                         cpu_req_valid_i,
    input  sdmac_pkg::reg_req_t          cpu_req_i,
    input  logic                         fifo_full_i,
    input  logic                         fifo_empty_i,
    input  logic [sdmac_pkg::BYTE_W-1:0] fifo_byte_i,
    output logic                         cpu_done_o,
    output logic [sdmac_pkg::BYTE_W-1:0] cpu_rdata_o,
    output sdmac_pkg::scsi_pins_t        pins_o,
    output sdmac_pkg::fifo_ctl_t         fifo_ctl_o
);

    import sdmac_pkg::*;

    scsi_state_e      state_q;
    scsi_state_e      state_d;
    logic             strb_cnt_q;
    logic [GAP_W-1:0] gap_q;
    logic             dreq_meta_q;
    logic             dreq_n_q;
    logic             dma_go;
    scsi_pins_t       pins_d;
    fifo_ctl_t        ctl_d;

    // DREQ comes from another clock domain
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            dreq_meta_q <= 1'b1;
            dreq_n_q    <= 1'b1;
        end else begin
            dreq_meta_q <= dreq_n_i;
            dreq_n_q    <= dreq_meta_q;
        end
    end

    // Room for a byte when reading the chip, a byte waiting when writing it
    assign dma_go = dma_en_i && !dreq_n_q && (gap_q == '0) &&
                    ((dma_dir_i == DIR_FROM_SCSI) ? !fifo_full_i : !fifo_empty_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Register access wins over the next DMA byte
                if (cpu_req_valid_i) begin
                    state_d = ST_REG_SETUP;
                end else if (dma_go) begin
                    state_d = ST_DMA_STROBE;
                end
            end
            ST_REG_SETUP: state_d = ST_REG_STROBE;
            ST_REG_STROBE: begin
                // Strobe is held for two cycles
                if (strb_cnt_q) begin
                    state_d = ST_REG_DONE;
                end
            end
            ST_REG_DONE:   state_d = ST_IDLE;
            ST_DMA_STROBE: state_d = ST_DMA_HOLD;
            ST_DMA_HOLD:   state_d = ST_IDLE;
            default:       state_d = ST_IDLE;
        endcase
    end

    // Pin values for the coming cycle, registered below
    always_comb begin
        pins_d = '0;
        ctl_d  = '0;
        case (state_d)
            ST_REG_SETUP, ST_REG_STROBE: begin
                pins_d.cs    = 1'b1;
                pins_d.addr  = cpu_req_i.addr;
                pins_d.wdata = cpu_req_i.wdata;
                pins_d.oe    = !cpu_req_i.rw;
                pins_d.re    = (state_d == ST_REG_STROBE) && cpu_req_i.rw;
                pins_d.we    = (state_d == ST_REG_STROBE) && !cpu_req_i.rw;
            end
            ST_DMA_STROBE, ST_DMA_HOLD: begin
                pins_d.dack  = 1'b1;
                pins_d.re    = (dma_dir_i == DIR_FROM_SCSI);
                pins_d.we    = (dma_dir_i == DIR_TO_SCSI);
                pins_d.oe    = (dma_dir_i == DIR_TO_SCSI);
                pins_d.wdata = fifo_byte_i;
            end
            default: begin
                pins_d = '0;
            end
        endcase

        // FIFO moves one byte in the cycle after the hold
        if (state_q == ST_DMA_HOLD) begin
            ctl_d.s2f    = (dma_dir_i == DIR_FROM_SCSI);
            ctl_d.f2s    = (dma_dir_i == DIR_TO_SCSI);
            ctl_d.inc_bo = 1'b1;
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state_q    <= ST_IDLE;
            strb_cnt_q <= 1'b0;
            gap_q      <= '0;
            pins_o     <= '0;
            fifo_ctl_o <= '0;
            cpu_done_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            pins_o     <= pins_d;
            fifo_ctl_o <= ctl_d;
            cpu_done_o <= (state_d == ST_REG_DONE);
            strb_cnt_q <= (state_q == ST_REG_STROBE) && !strb_cnt_q;
            if (state_q == ST_DMA_HOLD) begin
                gap_q <= GAP_W'(DMA_GAP);
            end else if (gap_q != '0) begin
                gap_q <= gap_q - 1'b1;
            end
        end
    end

    // Read data is taken at the end of the second strobe cycle
    always_ff @(posedge BCLK) begin
        if ((state_q == ST_REG_STROBE) && strb_cnt_q && cpu_req_i.rw) begin
            cpu_rdata_o <= scsi_data_i;
        end
    end

    // Register and DMA cycles never share the chip
    assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(pins_o.dack && pins_o.cs));

    assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(pins_o.re && pins_o.we));

endmodule

`default_nettype wire

// File: dma_fifo.sv
// Longword FIFO with byte packing
`timescale 1ns/100ps
`default_nettype none

module dma_fifo (
    input  logic                         BCLK,
    input  logic                         CRESET_,
    input  sdmac_pkg::dma_dir_e          dma_dir_i,
    input  logic                         host_in_valid_i,
    input  logic [sdmac_pkg::LONG_W-1:0] host_in_data_i,
    input  logic                         host_out_ready_i,
    input  logic [sdmac_pkg::BYTE_W-1:0] scsi_data_i,
    input  sdmac_pkg::fifo_ctl_t         fifo_ctl_i,
    output logic                         host_in_ready_o,
    output logic                         host_out_valid_o,
    output logic [sdmac_pkg::LONG_W-1:0] host_out_data_o,
    output logic [sdmac_pkg::BYTE_W-1:0] fifo_byte_o,
    output logic                         fifo_full_o,
    output logic                         fifo_empty_o
);

    import sdmac_pkg::*;

    logic [LONG_W-1:0]  mem_q [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_CW-1:0] count_q;
    logic [1:0]         bo_q;
    logic [1:0]         lane;
    logic               bo_eq3;
    logic [BYTE_W-1:0]  byte_q;
    logic               from_scsi;
    logic               push;
    logic               pop;

    assign from_scsi = (dma_dir_i == DIR_FROM_SCSI);
    assign bo_eq3    = (bo_q == 2'd3);
    // Byte 0 sits in the top lane
    assign lane      = ~bo_q;

    // A partly filled longword is not counted
    assign fifo_full_o  = (count_q == FIFO_CW'(FIFO_DEPTH));
    assign fifo_empty_o = (count_q == '0);

    assign host_in_ready_o  = !from_scsi && !fifo_full_o;
    assign host_out_valid_o = from_scsi && !fifo_empty_o;
    assign host_out_data_o  = mem_q[rd_ptr_q];
    assign fifo_byte_o      = mem_q[rd_ptr_q][{lane, 3'b000} +: BYTE_W];

    assign push = from_scsi ? (fifo_ctl_i.s2f && fifo_ctl_i.inc_bo && bo_eq3)
                            : (host_in_valid_i && host_in_ready_o);
    assign pop  = from_scsi ? (host_out_valid_o && host_out_ready_i)
                            : (fifo_ctl_i.f2s && fifo_ctl_i.inc_bo && bo_eq3);

    // Chip data is sampled during the hold cycle and written a cycle later
    always_ff @(posedge BCLK) begin
        byte_q <= scsi_data_i;
        if (from_scsi && fifo_ctl_i.s2f) begin
            mem_q[wr_ptr_q][{lane, 3'b000} +: BYTE_W] <= byte_q;
        end else if (!from_scsi && push) begin
            mem_q[wr_ptr_q] <= host_in_data_i;
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            bo_q     <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
            if (fifo_ctl_i.inc_bo) begin
                bo_q <= bo_q + 1'b1;
            end
        end
    end

    // Byte engine must have checked full before starting the last byte
    assert property (@(posedge BCLK) disable iff (!CRESET_)
        push |-> !fifo_full_o);

endmodule

`default_nettype wire

// File: sdmac_top.sv
// SCSI DMA controller top level
`timescale 1ns/100ps
`default_nettype none

module sdmac_top (
    input  logic                         BCLK,
    input  logic                         CRESET_,
    input  sdmac_pkg::dma_dir_e          dma_dir_i,
    input  logic                         dma_en_i,
    input  logic                         reg_req_valid_i,
    input  sdmac_pkg::reg_req_t          reg_req_i,
    input  logic                         host_in_valid_i,
    input  logic [sdmac_pkg::LONG_W-1:0] host_in_data_i,
    input  logic                         host_out_ready_i,
    input  logic                         dreq_n_i,
    input  logic [sdmac_pkg::BYTE_W-1:0] scsi_data_i,
    output logic                         reg_req_ready_o,
    output logic                         reg_ack_o,
    output logic [sdmac_pkg::BYTE_W-1:0] reg_rdata_o,
    output logic                         host_in_ready_o,
    output logic                         host_out_valid_o,
    output logic [sdmac_pkg::LONG_W-1:0] host_out_data_o,
    output sdmac_pkg::scsi_pins_t        scsi_pins_o
);

    import sdmac_pkg::*;

    reg_req_t          cpu_req;
    logic              cpu_req_valid;
    logic              cpu_done;
    logic [BYTE_W-1:0] cpu_rdata;
    logic [BYTE_W-1:0] fifo_byte;
    logic              fifo_full;
    logic              fifo_empty;
    fifo_ctl_t         fifo_ctl;

    cpu_port u_cpu_port (
        .BCLK            (BCLK),
        .CRESET_         (CRESET_),
        .reg_req_valid_i (reg_req_valid_i),
        .reg_req_i       (reg_req_i),
        .cpu_done_i      (cpu_done),
        .cpu_rdata_i     (cpu_rdata),
        .reg_req_ready_o (reg_req_ready_o),
        .reg_ack_o       (reg_ack_o),
        .reg_rdata_o     (reg_rdata_o),
        .cpu_req_valid_o (cpu_req_valid),
        .cpu_req_o       (cpu_req)
    );

    scsi_sm u_scsi_sm (
        .BCLK            (BCLK),
        .CRESET_         (CRESET_),
        .dma_dir_i       (dma_dir_i),
        .dma_en_i        (dma_en_i),
        .dreq_n_i        (dreq_n_i),
        .scsi_data_i     (scsi_data_i),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_req_i       (cpu_req),
        .fifo_full_i     (fifo_full),
        .fifo_empty_i    (fifo_empty),
        .fifo_byte_i     (fifo_byte),
        .cpu_done_o      (cpu_done),
        .cpu_rdata_o     (cpu_rdata),
        .pins_o          (scsi_pins_o),
        .fifo_ctl_o      (fifo_ctl)
    );

    dma_fifo u_dma_fifo (
        .BCLK             (BCLK),
        .CRESET_          (CRESET_),
        .dma_dir_i        (dma_dir_i),
        .host_in_valid_i  (host_in_valid_i),
        .host_in_data_i   (host_in_data_i),
        .host_out_ready_i (host_out_ready_i),
        .scsi_data_i      (scsi_data_i),
        .fifo_ctl_i       (fifo_ctl),
        .host_in_ready_o  (host_in_ready_o),
        .host_out_valid_o (host_out_valid_o),
        .host_out_data_o  (host_out_data_o),
        .fifo_byte_o      (fifo_byte),
        .fifo_full_o      (fifo_full),
        .fifo_empty_o     (fifo_empty)
    );

endmodule

`default_nettype wire

// File: tb_scsi_chip.sv
// Behavioral SCSI controller chip
`timescale 1ns/100ps
`default_nettype none

module tb_scsi_chip (
    input  logic                         BCLK,
    input  logic                         CRESET_,
    input  sdmac_pkg::scsi_pins_t        pins_i,
    input  logic                         job_start_i,
    input  logic [7:0]                   job_len_i,
    output logic [sdmac_pkg::BYTE_W-1:0] data_o,
    output logic                         dreq_n_o,
    output logic                         sink_valid_o,
    output logic [sdmac_pkg::BYTE_W-1:0] sink_byte_o,
    output logic                         stray_o
);

    import sdmac_pkg::*;

    logic [BYTE_W-1:0] regs_q [32];
    // Byte source for DMA reads, loaded by the testbench
    logic [BYTE_W-1:0] src_mem [64];
    logic [7:0]        len_q;
    logic [7:0]        cnt_q;
    logic              half_q;
    logic              byte_end;
    logic [BYTE_W-1:0] bus_wdata;

    // A DMA byte ends in the second cycle of DACK
    assign byte_end = pins_i.dack && half_q;
    assign dreq_n_o = !(cnt_q < len_q);

    // Undriven bus reads back as all ones
    assign data_o = (pins_i.dack && pins_i.re) ? src_mem[cnt_q[5:0]] :
                    (pins_i.cs && pins_i.re)   ? regs_q[pins_i.addr] : '1;

    // Write data only reaches the chip while the DUT drives the bus
    assign bus_wdata = pins_i.oe ? pins_i.wdata : '1;

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            len_q        <= '0;
            cnt_q        <= '0;
            half_q       <= 1'b0;
            sink_valid_o <= 1'b0;
            sink_byte_o  <= '0;
            stray_o      <= 1'b0;
        end else begin
            half_q       <= pins_i.dack && !half_q;
            sink_valid_o <= 1'b0;
            if (job_start_i) begin
                len_q   <= job_len_i;
                cnt_q   <= '0;
                stray_o <= 1'b0;
            end else if (byte_end) begin
                cnt_q <= cnt_q + 1'b1;
                // Acknowledge with no request pending
                if (cnt_q >= len_q) begin
                    stray_o <= 1'b1;
                end
                if (pins_i.we) begin
                    sink_valid_o <= 1'b1;
                    sink_byte_o  <= bus_wdata;
                end
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (pins_i.cs && pins_i.we) begin
            regs_q[pins_i.addr] <= bus_wdata;
        end
    end

endmodule

`default_nettype wire

// File: tb_sdmac.sv
// SCSI DMA controller testbench
`timescale 1ns/100ps
`default_nettype none

module tb_sdmac;

    import sdmac_pkg::*;

    // Test lengths in bytes, a register access counts as one byte
    localparam int REG_OPS         = 16;
    localparam int FROM_BYTES      = 32;
    localparam int TO_BYTES        = 32;
    localparam int BP_BYTES        = 40;
    localparam int MIX_BYTES       = 32;
    localparam int TEST_BYTES      = REG_OPS + FROM_BYTES + TO_BYTES + BP_BYTES + MIX_BYTES + 1;
    localparam int WATCHDOG_CYCLES = TEST_BYTES * 20 + 200;
    localparam int REG_LATENCY     = 6;

    logic                  BCLK;
    logic                  CRESET_;
    dma_dir_e              dma_dir;
    logic                  dma_en;
    logic                  reg_req_valid;
    reg_req_t              reg_req;
    logic                  reg_req_ready;
    logic                  reg_ack;
    logic [BYTE_W-1:0]     reg_rdata;
    logic                  host_in_valid;
    logic [LONG_W-1:0]     host_in_data;
    logic                  host_in_ready;
    logic                  host_out_valid;
    logic [LONG_W-1:0]     host_out_data;
    logic                  host_out_ready;
    logic                  dreq_n;
    logic [BYTE_W-1:0]     scsi_data;
    scsi_pins_t            scsi_pins;
    logic                  job_start;
    logic [7:0]            job_len;
    logic                  sink_valid;
    logic [BYTE_W-1:0]     sink_byte;
    logic                  chip_stray;
    logic                  fifo_full;

    int                    seed = 20631;
    int                    n_checks;
    int                    n_errors;
    int                    n_tests;
    int                    errors_before;
    logic [BYTE_W-1:0]     src_bytes [$];
    logic [LONG_W-1:0]     src_words [$];
    logic [LONG_W-1:0]     exp_long_q [$];
    logic [BYTE_W-1:0]     exp_byte_q [$];
    logic [BYTE_W-1:0]     reg_shadow [32];
    logic [REG_ADDR_W-1:0] reg_addrs [$];
    logic [LONG_W-1:0]     mon_long;
    logic [BYTE_W-1:0]     mon_byte;

    sdmac_top dut_i (
        .BCLK             (BCLK),
        .CRESET_          (CRESET_),
        .dma_dir_i        (dma_dir),
        .dma_en_i         (dma_en),
        .reg_req_valid_i  (reg_req_valid),
        .reg_req_i        (reg_req),
        .host_in_valid_i  (host_in_valid),
        .host_in_data_i   (host_in_data),
        .host_out_ready_i (host_out_ready),
        .dreq_n_i         (dreq_n),
        .scsi_data_i      (scsi_data),
        .reg_req_ready_o  (reg_req_ready),
        .reg_ack_o        (reg_ack),
        .reg_rdata_o      (reg_rdata),
        .host_in_ready_o  (host_in_ready),
        .host_out_valid_o (host_out_valid),
        .host_out_data_o  (host_out_data),
        .scsi_pins_o      (scsi_pins)
    );

    tb_scsi_chip chip_i (
        .BCLK         (BCLK),
        .CRESET_      (CRESET_),
        .pins_i       (scsi_pins),
        .job_start_i  (job_start),
        .job_len_i    (job_len),
        .data_o       (scsi_data),
        .dreq_n_o     (dreq_n),
        .sink_valid_o (sink_valid),
        .sink_byte_o  (sink_byte),
        .stray_o      (chip_stray)
    );

    // Full flag is not on the top level
    assign fifo_full = dut_i.u_dma_fifo.fifo_full_o;

    initial begin
        BCLK = 1'b0;
        forever #2 BCLK = ~BCLK;
    end

    // Big-endian, the first byte lands in bits 31:24
    function automatic logic [LONG_W-1:0] ref_pack(input logic [BYTE_W-1:0] bytes [$],
                                                   input int word);
        return {bytes[4*word], bytes[4*word+1], bytes[4*word+2], bytes[4*word+3]};
    endfunction

    function automatic logic [BYTE_W-1:0] ref_unpack(input logic [LONG_W-1:0] words [$],
                                                     input int idx);
        logic [LONG_W-1:0] w;
        w = words[idx / 4];
        return w[8 * (3 - idx % 4) +: 8];
    endfunction

    task automatic check(input string name, input logic [LONG_W-1:0] got,
                         input logic [LONG_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        n_errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("Test %0d %s done with %0d errors", n_tests, name, n_errors - errors_before);
        errors_before = n_errors;
    endtask

    // One host register access, returns read data and cycles from handshake to ack
    task automatic reg_access(input logic is_read, input logic [REG_ADDR_W-1:0] addr,
                              input logic [BYTE_W-1:0] wdata,
                              output logic [BYTE_W-1:0] rdata, output int latency);
        int waited;
        waited = 0;
        while (!reg_req_ready && waited < 200) begin
            @(negedge BCLK);
            waited++;
        end
        if (!reg_req_ready) begin
            report_error("register port never became ready");
        end
        reg_req_valid = 1'b1;
        reg_req.rw    = is_read;
        reg_req.addr  = addr;
        reg_req.wdata = wdata;
        @(negedge BCLK);
        reg_req_valid = 1'b0;
        latency = 0;
        while (!reg_ack && latency < 200) begin
            @(negedge BCLK);
            latency++;
        end
        if (!reg_ack) begin
            report_error("register access got no acknowledge");
        end
        rdata = reg_rdata;
    endtask

    task automatic push_longword(input logic [LONG_W-1:0] word);
        int waited;
        waited = 0;
        host_in_valid = 1'b1;
        host_in_data  = word;
        while (!host_in_ready && waited < 200) begin
            @(negedge BCLK);
            waited++;
        end
        if (!host_in_ready) begin
            report_error("host_in never became ready");
        end
        @(negedge BCLK);
        host_in_valid = 1'b0;
    endtask

    // Random source bytes in the chip, expected longwords in the queue
    task automatic load_source(input int n_bytes);
        src_bytes.delete();
        for (int i = 0; i < n_bytes; i++) begin
            src_bytes.push_back(8'($random(seed)));
            chip_i.src_mem[i] = src_bytes[i];
        end
        for (int w = 0; w < n_bytes / 4; w++) begin
            exp_long_q.push_back(ref_pack(src_bytes, w));
        end
    endtask

    task automatic start_job(input dma_dir_e dir, input int n_bytes);
        dma_dir   = dir;
        dma_en    = 1'b1;
        job_len   = 8'(n_bytes);
        job_start = 1'b1;
        @(negedge BCLK);
        job_start = 1'b0;
    endtask

    task automatic wait_drained(input int n_bytes);
        int waited;
        waited = 0;
        while ((exp_long_q.size() != 0 || exp_byte_q.size() != 0) && waited < n_bytes * 20) begin
            @(negedge BCLK);
            waited++;
        end
        if (exp_long_q.size() != 0 || exp_byte_q.size() != 0) begin
            report_error($sformatf("DMA stalled with %0d longwords and %0d bytes missing",
                                   exp_long_q.size(), exp_byte_q.size()));
            exp_long_q.delete();
            exp_byte_q.delete();
        end
        // Let the last byte cycle and DREQ settle before the engine is turned off
        repeat (8) @(negedge BCLK);
        dma_en = 1'b0;
        if (chip_stray) begin
            report_error("SCSI chip saw a DMA byte it had not requested");
        end
    endtask

    // Compares the host_out and SCSI sink streams with the expected queues
    always @(posedge BCLK) begin
        if (CRESET_ && host_out_valid && host_out_ready) begin
            if (exp_long_q.size() == 0) begin
                report_error("host_out delivered an extra longword");
            end else begin
                mon_long = exp_long_q.pop_front();
                check("host_out_data_o", host_out_data, mon_long);
            end
        end
        if (CRESET_ && sink_valid) begin
            if (exp_byte_q.size() == 0) begin
                report_error("SCSI chip received an extra byte");
            end else begin
                mon_byte = exp_byte_q.pop_front();
                check("scsi_pins_o.wdata", sink_byte, mon_byte);
            end
        end
        if (CRESET_ && dma_dir == DIR_FROM_SCSI && fifo_full && scsi_pins.dack) begin
            report_error("DMA acknowledge while the FIFO is full");
        end
        if (CRESET_ && scsi_pins.re && scsi_pins.oe) begin
            report_error("DUT drives the SCSI data bus during a read strobe");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge BCLK);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [BYTE_W-1:0]     rdata;
        logic [REG_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]     data;
        int                    latency;
        int                    waited;

        CRESET_        = 1'b0;
        dma_dir        = DIR_FROM_SCSI;
        dma_en         = 1'b0;
        reg_req_valid  = 1'b0;
        reg_req        = '0;
        host_in_valid  = 1'b0;
        host_in_data   = '0;
        host_out_ready = 1'b0;
        job_start      = 1'b0;
        job_len        = '0;
        n_checks       = 0;
        n_errors       = 0;
        n_tests        = 0;
        errors_before  = 0;
        repeat (4) @(posedge BCLK);
        @(negedge BCLK);
        CRESET_ = 1'b1;
        @(negedge BCLK);

        check("scsi_pins_o strobes", {scsi_pins.cs, scsi_pins.re, scsi_pins.we,
                                      scsi_pins.dack}, '0);
        check("host_out_valid_o", host_out_valid, 1'b0);
        check("reg_ack_o", reg_ack, 1'b0);
        check("reg_req_ready_o", reg_req_ready, 1'b1);
        end_test("after reset");

        for (int i = 0; i < REG_OPS / 2; i++) begin
            addr = REG_ADDR_W'($random(seed));
            data = BYTE_W'($random(seed));
            reg_access(1'b0, addr, data, rdata, latency);
            check("reg_ack_o latency", latency, REG_LATENCY);
            reg_shadow[addr] = data;
            reg_addrs.push_back(addr);
        end
        foreach (reg_addrs[i]) begin
            reg_access(1'b1, reg_addrs[i], '0, rdata, latency);
            check("reg_rdata_o", rdata, reg_shadow[reg_addrs[i]]);
            check("reg_ack_o latency", latency, REG_LATENCY);
        end
        end_test("register access");

        host_out_ready = 1'b1;
        load_source(FROM_BYTES);
        start_job(DIR_FROM_SCSI, FROM_BYTES);
        wait_drained(FROM_BYTES);
        end_test("DMA from SCSI");

        src_words.delete();
        for (int w = 0; w < TO_BYTES / 4; w++) begin
            src_words.push_back(LONG_W'($random(seed)));
        end
        for (int i = 0; i < TO_BYTES; i++) begin
            exp_byte_q.push_back(ref_unpack(src_words, i));
        end
        start_job(DIR_TO_SCSI, TO_BYTES);
        foreach (src_words[w]) begin
            push_longword(src_words[w]);
        end
        wait_drained(TO_BYTES);
        end_test("DMA to SCSI");

        // More bytes than the FIFO holds, so DREQ stays low while it is full
        host_out_ready = 1'b0;
        load_source(BP_BYTES);
        start_job(DIR_FROM_SCSI, BP_BYTES);
        waited = 0;
        while (!fifo_full && waited < BP_BYTES * 20) begin
            @(negedge BCLK);
            waited++;
        end
        if (!fifo_full) begin
            report_error("FIFO never filled while host_out was stalled");
        end
        repeat (30) @(negedge BCLK);
        // The chip has handed over exactly one full FIFO of bytes
        check("chip_i.cnt_q", chip_i.cnt_q, FIFO_DEPTH * 4);
        host_out_ready = 1'b1;
        wait_drained(BP_BYTES);
        end_test("back-pressure");

        load_source(MIX_BYTES);
        start_job(DIR_FROM_SCSI, MIX_BYTES);
        repeat (20) @(negedge BCLK);
        reg_access(1'b1, reg_addrs[0], '0, rdata, latency);
        check("reg_rdata_o", rdata, reg_shadow[reg_addrs[0]]);
        wait_drained(MIX_BYTES);
        end_test("register access during DMA");

        $display("Tests run: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sdmac.f
sdmac_pkg.sv
cpu_port.sv
scsi_sm.sv
dma_fifo.sv
sdmac_top.sv
tb_scsi_chip.sv
tb_sdmac.sv

// File: Bender.yml
package:
  name: sdmac

sources:
  - sdmac_pkg.sv
  - cpu_port.sv
  - scsi_sm.sv
  - dma_fifo.sv
  - sdmac_top.sv
  - target: test
    files:
      - tb_scsi_chip.sv
      - tb_sdmac.sv
